// ==== rtl/hdc_params.svh ====
`ifndef HDC_PARAMS_SVH
`define HDC_PARAMS_SVH

// hypervector geometry
`define HV_DIM 256

// dimensions processed per clock cycle
`define DIMS_PER_CC 32

// chunks per hypervector, HV_DIM / DIMS_PER_CC
`define SEQ_CYCLE_COUNT 8

// class set
`define NUM_CLASSES 4
`define CLASS_W 2

// nonbinary counter width per dimension, saturates at all ones
`define BITWIDTH_PER_DIM 6

// per-class sample count width, saturates at all ones
`define CNT_W 6

`endif

// ==== rtl/hdc_pkg.sv ====
`include "hdc_params.svh"

package hdc_pkg;

    // one encoded training sample with its label
    typedef struct packed {
        logic [`HV_DIM-1:0]  encoded_hv;
        logic [`CLASS_W-1:0] class_id;
        logic                train;
    } hdc_sample_t;

    // per-cycle control word from the sequencer
    typedef struct packed {
        logic                                bundling;
        logic                                binarizing;
        logic [$clog2(`SEQ_CYCLE_COUNT)-1:0] chunk_idx;
        logic [`CLASS_W-1:0]                 class_idx;
        // set on chunk 0 of a bundled sample
        logic                                first;
    } hdc_ctrl_t;

endpackage

// ==== rtl/class_fsm.sv ====
`timescale 1ns/1ps
`include "hdc_params.svh"

module class_fsm
    import hdc_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       en,
    input  logic       start_class_gen,
    input  logic       training_dataset_finished,
    output hdc_ctrl_t  ctrl,
    output logic       busy,
    output logic       class_gen_done
);

    localparam int CHUNK_W = $clog2(`SEQ_CYCLE_COUNT);

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_BUNDLE   = 2'd1;
    localparam logic [1:0] ST_BINARIZE = 2'd2;

    localparam logic [CHUNK_W-1:0]  LAST_CHUNK = CHUNK_W'(`SEQ_CYCLE_COUNT - 1);
    localparam logic [`CLASS_W-1:0] LAST_CLASS = `CLASS_W'(`NUM_CLASSES - 1);

    logic [1:0]          state;
    logic [CHUNK_W-1:0]  chunk_cnt;
    logic [`CLASS_W-1:0] class_cnt;
    logic                last_chunk;
    logic                last_class;

    assign last_chunk = (chunk_cnt == LAST_CHUNK);
    assign last_class = (class_cnt == LAST_CLASS);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state          <= ST_IDLE;
            chunk_cnt      <= '0;
            class_cnt      <= '0;
            class_gen_done <= 1'b0;
        end else begin
            // done lasts one cycle even if en drops right after
            class_gen_done <= en && (state == ST_BINARIZE) && last_chunk && last_class;
            if (en) begin
                case (state)
                    ST_IDLE: begin
                        chunk_cnt <= '0;
                        class_cnt <= '0;
                        // start wins over finish
                        if (start_class_gen) begin
                            state <= ST_BUNDLE;
                        end else if (training_dataset_finished) begin
                            state <= ST_BINARIZE;
                        end
                    end
                    ST_BUNDLE: begin
                        if (last_chunk) begin
                            chunk_cnt <= '0;
                            state     <= ST_IDLE;
                        end else begin
                            chunk_cnt <= chunk_cnt + 1'b1;
                        end
                    end
                    ST_BINARIZE: begin
                        if (last_chunk) begin
                            chunk_cnt <= '0;
                            if (last_class) begin
                                class_cnt <= '0;
                                state     <= ST_IDLE;
                            end else begin
                                class_cnt <= class_cnt + 1'b1;
                            end
                        end else begin
                            chunk_cnt <= chunk_cnt + 1'b1;
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    assign busy = (state != ST_IDLE);

    always_comb begin
        ctrl            = '0;
        ctrl.bundling   = (state == ST_BUNDLE);
        ctrl.binarizing = (state == ST_BINARIZE);
        ctrl.chunk_idx  = chunk_cnt;
        ctrl.class_idx  = class_cnt;
        ctrl.first      = (state == ST_BUNDLE) && (chunk_cnt == '0);
    end

endmodule

// ==== rtl/class_accumulator.sv ====
`timescale 1ns/1ps
`include "hdc_params.svh"

module class_accumulator
    import hdc_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        en,
    input  logic        start_class_gen,
    input  logic        busy,
    input  hdc_sample_t sample,
    input  hdc_ctrl_t   ctrl,
    output logic [`DIMS_PER_CC-1:0][`BITWIDTH_PER_DIM-1:0] class_chunk,
    output logic [`CNT_W-1:0]                              class_count
);

    localparam logic [`BITWIDTH_PER_DIM-1:0] CTR_MAX = '1;
    localparam logic [`CNT_W-1:0]            CNT_MAX = '1;

    // nonbinary class counters, one row per class and chunk
    logic [`NUM_CLASSES-1:0][`SEQ_CYCLE_COUNT-1:0][`DIMS_PER_CC-1:0][`BITWIDTH_PER_DIM-1:0]
        ctr_mem;
    logic [`NUM_CLASSES-1:0][`CNT_W-1:0]             sample_cnt;
    hdc_sample_t                                     sample_q;
    logic [`CLASS_W-1:0]                             rd_class;
    logic [`DIMS_PER_CC-1:0]                         in_chunk;
    logic [`DIMS_PER_CC-1:0][`BITWIDTH_PER_DIM-1:0]  sum_chunk;

    // capture on the accepting edge only
    always_ff @(posedge clk) begin
        if (en && start_class_gen && !busy) begin
            sample_q <= sample;
        end
    end

    // the sample class addresses the memory while bundling
    assign rd_class    = ctrl.bundling ? sample_q.class_id : ctrl.class_idx;
    assign class_chunk = ctr_mem[rd_class][ctrl.chunk_idx];
    assign class_count = sample_cnt[rd_class];
    assign in_chunk    = sample_q.encoded_hv[ctrl.chunk_idx*`DIMS_PER_CC +: `DIMS_PER_CC];

    // saturating add, or plain replace for a first sample
    always_comb begin
        for (int d = 0; d < `DIMS_PER_CC; d++) begin
            if (!sample_q.train) begin
                sum_chunk[d] = `BITWIDTH_PER_DIM'(in_chunk[d]);
            end else if (class_chunk[d] == CTR_MAX) begin
                sum_chunk[d] = class_chunk[d];
            end else begin
                sum_chunk[d] = class_chunk[d] + `BITWIDTH_PER_DIM'(in_chunk[d]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            ctr_mem    <= '0;
            sample_cnt <= '0;
        end else if (en && ctrl.bundling) begin
            ctr_mem[sample_q.class_id][ctrl.chunk_idx] <= sum_chunk;
            if (ctrl.first) begin
                if (!sample_q.train) begin
                    sample_cnt[sample_q.class_id] <= `CNT_W'(1);
                end else if (sample_cnt[sample_q.class_id] != CNT_MAX) begin
                    sample_cnt[sample_q.class_id] <= sample_cnt[sample_q.class_id] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/class_binarizer.sv ====
`timescale 1ns/1ps
`include "hdc_params.svh"

module class_binarizer
    import hdc_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  logic      en,
    input  hdc_ctrl_t ctrl,
    input  logic [`DIMS_PER_CC-1:0][`BITWIDTH_PER_DIM-1:0] class_chunk,
    input  logic [`CNT_W-1:0]                              class_count,
    output logic [`NUM_CLASSES-1:0][`HV_DIM-1:0]           bin_class_hvs
);

    logic [`CNT_W-1:0]       threshold;
    logic [`DIMS_PER_CC-1:0] bin_chunk;

    // half the sample count, rounded down
    assign threshold = class_count >> 1;

    // strict majority, so a tie gives 0
    always_comb begin
        for (int d = 0; d < `DIMS_PER_CC; d++) begin
            bin_chunk[d] = (`CNT_W'(class_chunk[d]) > threshold);
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            bin_class_hvs <= '0;
        end else if (en && ctrl.binarizing) begin
            bin_class_hvs[ctrl.class_idx][ctrl.chunk_idx*`DIMS_PER_CC +: `DIMS_PER_CC]
                <= bin_chunk;
        end
    end

endmodule

// ==== rtl/class_hv_gen_top.sv ====
`timescale 1ns/1ps
`include "hdc_params.svh"

module class_hv_gen_top
    import hdc_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        en,
    input  logic        start_class_gen,
    input  hdc_sample_t sample,
    input  logic        training_dataset_finished,
    output logic        busy,
    output logic        class_gen_done,
    output logic [`NUM_CLASSES-1:0][`HV_DIM-1:0] bin_class_hvs
);

    hdc_ctrl_t                                      ctrl;
    logic [`DIMS_PER_CC-1:0][`BITWIDTH_PER_DIM-1:0] class_chunk;
    logic [`CNT_W-1:0]                              class_count;

    class_fsm u_fsm (
        .clk                       (clk),
        .nrst                      (nrst),
        .en                        (en),
        .start_class_gen           (start_class_gen),
        .training_dataset_finished (training_dataset_finished),
        .ctrl                      (ctrl),
        .busy                      (busy),
        .class_gen_done            (class_gen_done)
    );

    class_accumulator u_acc (
        .clk             (clk),
        .nrst            (nrst),
        .en              (en),
        .start_class_gen (start_class_gen),
        .busy            (busy),
        .sample          (sample),
        .ctrl            (ctrl),
        .class_chunk     (class_chunk),
        .class_count     (class_count)
    );

    class_binarizer u_bin (
        .clk           (clk),
        .nrst          (nrst),
        .en            (en),
        .ctrl          (ctrl),
        .class_chunk   (class_chunk),
        .class_count   (class_count),
        .bin_class_hvs (bin_class_hvs)
    );

endmodule

// ==== tests/class_hv_gen_checker.sv ====
`timescale 1ns/1ps
`include "hdc_params.svh"

module class_hv_gen_checker
    import hdc_pkg::*;
(
    input logic      clk,
    input logic      nrst,
    input logic      en,
    input hdc_ctrl_t ctrl,
    input logic      busy,
    input logic      class_gen_done
);

    int unsigned bundle_len;
    int unsigned fail_count = 0;

    // enabled cycles spent in the current bundle phase
    always_ff @(posedge clk) begin
        if (!nrst || !ctrl.bundling) begin
            bundle_len <= 0;
        end else if (en) begin
            bundle_len <= bundle_len + 1;
        end
    end

    bundle_length: assert property (@(posedge clk) disable iff (!nrst)
        $fell(ctrl.bundling) |-> bundle_len == `SEQ_CYCLE_COUNT)
    else begin
        $error("bundle phase did not last %0d enabled cycles", `SEQ_CYCLE_COUNT);
        fail_count++;
    end

    done_single: assert property (@(posedge clk) disable iff (!nrst)
        class_gen_done |=> !class_gen_done)
    else begin
        $error("class_gen_done stayed high for more than one cycle");
        fail_count++;
    end

    reset_idle: assert property (@(posedge clk) !nrst |=> !busy)
    else begin
        $error("busy was high right after reset");
        fail_count++;
    end

    phase_exclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(ctrl.bundling && ctrl.binarizing))
    else begin
        $error("bundling and binarizing were set together");
        fail_count++;
    end

endmodule

bind class_fsm class_hv_gen_checker u_chk (.*);

// ==== tests/class_hv_gen_tb.sv ====
`timescale 1ns/1ps
`include "hdc_params.svh"

module class_hv_gen_tb
    import hdc_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int CTR_MAX        = (1 << `BITWIDTH_PER_DIM) - 1;
    localparam int CNT_MAX        = (1 << `CNT_W) - 1;
    localparam int BIN_CYCLES     = `NUM_CLASSES * `SEQ_CYCLE_COUNT;

    logic        clk = 1'b0;
    logic        nrst;
    logic        en;
    logic        start_class_gen;
    logic        training_dataset_finished;
    hdc_sample_t sample;
    logic        busy;
    logic        class_gen_done;
    logic [`NUM_CLASSES-1:0][`HV_DIM-1:0] bin_class_hvs;

    // reference counters per class and dimension
    int ref_ctr [`NUM_CLASSES][`HV_DIM];
    int ref_cnt [`NUM_CLASSES];
    int error_count = 0;
    int done_count  = 0;
    int cycle_count = 0;

    class_hv_gen_top dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        error_count++;
    endtask

    function automatic logic [`HV_DIM-1:0] rand_hv();
        logic [`HV_DIM-1:0] hv;
        for (int w = 0; w < `HV_DIM / 32; w++) begin
            hv[w*32 +: 32] = $urandom;
        end
        return hv;
    endfunction

    // saturating add, or replace when train is low
    function automatic void model_sample(input int cls, input logic train,
                                         input logic [`HV_DIM-1:0] hv);
        for (int d = 0; d < `HV_DIM; d++) begin
            if (!train) begin
                ref_ctr[cls][d] = hv[d];
            end else if (ref_ctr[cls][d] < CTR_MAX) begin
                ref_ctr[cls][d] += hv[d];
            end
        end
        if (!train) begin
            ref_cnt[cls] = 1;
        end else if (ref_cnt[cls] < CNT_MAX) begin
            ref_cnt[cls]++;
        end
    endfunction

    // strict majority against half the count, so ties give 0
    function automatic logic [`HV_DIM-1:0] ref_binarize(input int cls);
        logic [`HV_DIM-1:0] hv;
        for (int d = 0; d < `HV_DIM; d++) begin
            hv[d] = (ref_ctr[cls][d] > ref_cnt[cls] / 2);
        end
        return hv;
    endfunction

    task automatic apply_sample(input int cls, input logic train,
                                input logic [`HV_DIM-1:0] hv, input bit toggle_en);
        int en_cycles;
        @(negedge clk);
        assert (!busy) else report_error("busy high before a new start");
        en                = 1'b1;
        start_class_gen   = 1'b1;
        sample.encoded_hv = hv;
        sample.class_id   = `CLASS_W'(cls);
        sample.train      = train;
        model_sample(cls, train, hv);
        en_cycles = 0;
        forever begin
            @(negedge clk);
            start_class_gen = 1'b0;
            if (!busy) break;
            en = toggle_en ? 1'($urandom_range(0, 1)) : 1'b1;
            if (en) en_cycles++;
            // starts while busy must be dropped
            start_class_gen   = ($urandom_range(0, 3) == 0);
            sample.encoded_hv = rand_hv();
            sample.train      = 1'b0;
        end
        en = 1'b1;
        assert (en_cycles == `SEQ_CYCLE_COUNT)
        else report_error($sformatf("busy for %0d enabled cycles, expected %0d",
                                    en_cycles, `SEQ_CYCLE_COUNT));
    endtask

    task automatic finish_dataset(input bit toggle_en);
        int cycles;
        int lows;
        @(negedge clk);
        en                        = 1'b1;
        training_dataset_finished = 1'b1;
        cycles = 0;
        lows   = 0;
        forever begin
            @(negedge clk);
            training_dataset_finished = 1'b0;
            cycles++;
            if (class_gen_done) break;
            en = toggle_en ? 1'($urandom_range(0, 1)) : 1'b1;
            if (!en) lows++;
        end
        en = 1'b1;
        assert (cycles == BIN_CYCLES + 1 + lows && !busy)
        else report_error($sformatf("done after %0d cycles with %0d stalls, busy %b",
                                    cycles, lows, busy));
    endtask

    task automatic train_round(input bit toggle_en, input int max_train);
        int n;
        for (int c = 0; c < `NUM_CLASSES; c++) begin
            apply_sample(c, 1'b0, rand_hv(), toggle_en);
            n = $urandom_range(2, max_train);
            repeat (n) apply_sample(c, 1'b1, rand_hv(), toggle_en);
        end
    endtask

    // compare every class once a done pulse is seen
    always @(negedge clk) begin
        if (class_gen_done) begin
            done_count++;
            for (int c = 0; c < `NUM_CLASSES; c++) begin
                assert (bin_class_hvs[c] == ref_binarize(c))
                else report_error($sformatf("class %0d got %h expected %h",
                                            c, bin_class_hvs[c], ref_binarize(c)));
            end
        end
    end

    initial begin
        logic [`NUM_CLASSES-1:0][`HV_DIM-1:0] prev_hvs;
        logic [`HV_DIM-1:0]                   hv;
        void'($urandom(32'hb8a1));
        nrst                      = 1'b0;
        en                        = 1'b0;
        start_class_gen           = 1'b0;
        training_dataset_finished = 1'b0;
        sample                    = '0;
        repeat (16) @(negedge clk);
        nrst = 1'b1;
        en   = 1'b1;
        assert (!busy && !class_gen_done && bin_class_hvs == '0)
        else report_error("outputs not idle and zero after reset");

        train_round(1'b0, 9);
        finish_dataset(1'b0);

        // stalls must not change the result
        train_round(1'b1, 2);
        finish_dataset(1'b1);

        prev_hvs = bin_class_hvs;
        finish_dataset(1'b0);
        assert (bin_class_hvs == prev_hvs) else report_error("second finish changed the result");

        hv = rand_hv();
        apply_sample(1, 1'b0, hv, 1'b0);
        finish_dataset(1'b0);
        assert (bin_class_hvs[1] == hv) else report_error("replaced class differs from sample");

        repeat (70) apply_sample(3, 1'b1, '1, 1'b0);
        finish_dataset(1'b0);
        assert (bin_class_hvs[3] == '1 && dut.u_acc.sample_cnt[3] == CNT_MAX
                && dut.u_acc.ctr_mem[3][0][0] == CTR_MAX)
        else report_error("saturated class is not all ones at full count");

        @(negedge clk);
        assert (done_count == 5)
        else report_error($sformatf("saw %0d done pulses, expected 5", done_count));
        $display("errors: %0d, checker assertion failures: %0d",
                 error_count, dut.u_fsm.u_chk.fail_count);
        if (error_count == 0 && dut.u_fsm.u_chk.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/hdc_pkg.sv
rtl/class_fsm.sv
rtl/class_accumulator.sv
rtl/class_binarizer.sv
rtl/class_hv_gen_top.sv
tests/class_hv_gen_checker.sv
tests/class_hv_gen_tb.sv

// ==== Bender.yml ====
package:
  name: class_hv_gen

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/hdc_pkg.sv
      - rtl/class_fsm.sv
      - rtl/class_accumulator.sv
      - rtl/class_binarizer.sv
      - rtl/class_hv_gen_top.sv
  - target: test
    files:
      - tests/class_hv_gen_checker.sv
      - tests/class_hv_gen_tb.sv
